// File: include/video_config.svh
// Video configuration.
// Timing for 640x480 at 800x525 total, sprite size, fixed colours
// and the latency through the sprite overlay stage.

`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// horizontal timing, in pixels.
`define H_ACTIVE 640
`define H_FRONT  16
`define H_SYNC   96
`define H_TOTAL  800

// vertical timing, in lines.
`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_TOTAL  525

// sprite image size.
`define SPRITE_WIDTH  64
`define SPRITE_HEIGHT 64

// colour forced on blanked pixels by the sprite stage.
`define BLANK_RGB 12'h888

// cycles from sprite stage input to output.
`define SPRITE_LATENCY 3

`endif

// File: hdl/video_pkg.sv
// Video package.
// Types shared along the pixel pipeline: counts, positions,
// colours, sprite image addresses and the video bus word.

`default_nettype none

package video_pkg;

    // pixel or line count.
    typedef logic [10:0] coord_t;

    // sprite position, wider than a count.
    typedef logic [11:0] pos_t;

    // 4:4:4 colour, red in the top nibble.
    typedef logic [11:0] rgb_t;

    // image address, row in the upper six bits, column below.
    typedef logic [11:0] sprite_addr_t;

    // one pixel on the bus with its position and timing flags.
    typedef struct packed {
        coord_t hcount;
        logic   hsync;
        logic   hblnk;
        coord_t vcount;
        logic   vsync;
        logic   vblnk;
        rgb_t   rgb;
    } video_bus_t;

endpackage

`default_nettype wire

// File: hdl/vga_timing.sv
// VGA timing generator.
// Counts pixels and lines over the 800x525 frame and decodes the
// sync and blanking flags. All outputs are registered, so every
// flag belongs to the counts of the same word. Paces the pipeline.

`default_nettype none

`include "video_config.svh"

module vga_timing (
    input  wire logic              clk,
    input  wire logic              rst,
    output video_pkg::video_bus_t timing
);

    localparam video_pkg::coord_t H_LAST     = video_pkg::coord_t'(`H_TOTAL - 1);
    localparam video_pkg::coord_t V_LAST     = video_pkg::coord_t'(`V_TOTAL - 1);
    localparam video_pkg::coord_t H_SYNC_ON  = video_pkg::coord_t'(`H_ACTIVE + `H_FRONT);
    localparam video_pkg::coord_t H_SYNC_OFF =
        video_pkg::coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam video_pkg::coord_t V_SYNC_ON  = video_pkg::coord_t'(`V_ACTIVE + `V_FRONT);
    localparam video_pkg::coord_t V_SYNC_OFF =
        video_pkg::coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);
    localparam video_pkg::coord_t H_BLANK_ON = video_pkg::coord_t'(`H_ACTIVE);
    localparam video_pkg::coord_t V_BLANK_ON = video_pkg::coord_t'(`V_ACTIVE);

    video_pkg::coord_t     h_nxt;
    video_pkg::coord_t     v_nxt;
    video_pkg::video_bus_t timing_nxt;

    // counter advance; vcount steps on the hcount wrap.
    always_comb begin
        h_nxt = timing.hcount + 1'b1;
        v_nxt = timing.vcount;
        if (timing.hcount == H_LAST) begin
            h_nxt = '0;
            if (timing.vcount == V_LAST) begin
                v_nxt = '0;
            end else begin
                v_nxt = timing.vcount + 1'b1;
            end
        end
    end

    // decode from the next counts so flags line up after the register.
    always_comb begin
        timing_nxt.hcount = h_nxt;
        timing_nxt.hsync  = (h_nxt >= H_SYNC_ON) && (h_nxt < H_SYNC_OFF);
        timing_nxt.hblnk  = (h_nxt >= H_BLANK_ON);
        timing_nxt.vcount = v_nxt;
        timing_nxt.vsync  = (v_nxt >= V_SYNC_ON) && (v_nxt < V_SYNC_OFF);
        timing_nxt.vblnk  = (v_nxt >= V_BLANK_ON);
        timing_nxt.rgb    = '0;                      // colour is added downstream.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            timing <= '0;
        end else begin
            timing <= timing_nxt;
        end
    end

endmodule

`default_nettype wire

// File: hdl/draw_background.sv
// Background stage.
// Paints a coarse colour grid on active pixels from the upper count
// bits and black on blanked pixels, one cycle from input to output.

`default_nettype none

module draw_background (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire video_pkg::video_bus_t bus_in,
    output video_pkg::video_bus_t      bus_out
);

    video_pkg::video_bus_t bus_nxt;

    always_comb begin
        bus_nxt = bus_in;
        if (bus_in.hblnk || bus_in.vblnk) begin
            bus_nxt.rgb = '0;
        end else begin
            // red from the column band, green from the row band.
            bus_nxt.rgb = {bus_in.hcount[8:5], bus_in.vcount[8:5], 4'h0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out <= '0;
        end else begin
            bus_out <= bus_nxt;
        end
    end

endmodule

`default_nettype wire

// File: hdl/bus_delay.sv
// Video bus delay line.
// Shifts the whole bus word through DEPTH registers so that it
// lines up with data arriving DEPTH cycles later.

`default_nettype none

module bus_delay #(
    parameter int DEPTH = 2
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire video_pkg::video_bus_t bus_in,
    output video_pkg::video_bus_t      bus_out
);

    video_pkg::video_bus_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= bus_in;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i - 1];
            end
        end
    end

    assign bus_out = stage[DEPTH - 1];           // oldest word leaves.

endmodule

`default_nettype wire

// File: hdl/sprite_rom.sv
// Sprite image memory.
// 64x64 pixels of 12-bit colour with a registered read port.
// Contents come from a fixed rule: red follows the row, green the
// column, blue is constant.

`default_nettype none

module sprite_rom (
    input  wire logic                     clk,
    input  wire video_pkg::sprite_addr_t addr,
    output video_pkg::rgb_t              rgb
);

    localparam int ENTRIES = 2 ** $bits(video_pkg::sprite_addr_t);

    video_pkg::rgb_t mem [ENTRIES];

    // row sits in addr[11:6], column in addr[5:0].
    initial begin
        for (int i = 0; i < ENTRIES; i++) begin
            mem[i] = {i[11:8], i[5:2], 4'hc};
        end
    end

    always_ff @(posedge clk) begin
        rgb <= mem[addr];                        // data one cycle after address.
    end

endmodule

`default_nettype wire

// File: hdl/draw_sprite.sv
// Sprite overlay stage.
// Looks up the sprite image for the incoming pixel, with optional
// horizontal mirroring, and draws it inside a 64x64 box at xpos, ypos.
// Blanked pixels get a fixed grey. Three cycles from input to output.

`default_nettype none

`include "video_config.svh"

module draw_sprite (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire video_pkg::pos_t       xpos,
    input  wire video_pkg::pos_t       ypos,
    input  wire logic                   rotate,
    input  wire video_pkg::rgb_t       sprite_rgb,
    output video_pkg::sprite_addr_t    sprite_addr,
    input  wire video_pkg::video_bus_t bus_in,
    output video_pkg::video_bus_t      bus_out
);

    localparam video_pkg::pos_t SPR_W   = video_pkg::pos_t'(`SPRITE_WIDTH);
    localparam video_pkg::pos_t SPR_H   = video_pkg::pos_t'(`SPRITE_HEIGHT);
    localparam logic [5:0]      COL_MAX = 6'(`SPRITE_WIDTH - 1);

    video_pkg::video_bus_t   bus_dly;
    video_pkg::video_bus_t   bus_nxt;
    video_pkg::sprite_addr_t addr_nxt;
    video_pkg::pos_t         x_off;
    video_pkg::pos_t         y_off;
    video_pkg::pos_t         x_dly;
    video_pkg::pos_t         y_dly;
    logic [5:0]              col;
    logic                    in_box;

    // bus waits for the address register plus the ROM read.
    bus_delay #(
        .DEPTH(`SPRITE_LATENCY - 1)
    ) u_bus_delay (
        .clk,
        .rst,
        .bus_in,
        .bus_out(bus_dly)
    );

    // address from the undelayed counts.
    always_comb begin
        y_off = video_pkg::pos_t'(bus_in.vcount) - ypos;
        x_off = video_pkg::pos_t'(bus_in.hcount) - xpos;
        if (rotate) begin
            col = COL_MAX - x_off[5:0];          // mirrored column.
        end else begin
            col = x_off[5:0];
        end
        addr_nxt = {y_off[5:0], col};
    end

    // merge on the cycle where ROM data matches the delayed bus.
    always_comb begin
        x_dly   = video_pkg::pos_t'(bus_dly.hcount);
        y_dly   = video_pkg::pos_t'(bus_dly.vcount);
        in_box  = (x_dly >= xpos) && (x_dly < xpos + SPR_W) &&
                  (y_dly >= ypos) && (y_dly < ypos + SPR_H);
        bus_nxt = bus_dly;
        if (bus_dly.hblnk || bus_dly.vblnk) begin
            bus_nxt.rgb = `BLANK_RGB;
        end else if (in_box) begin
            bus_nxt.rgb = sprite_rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out     <= '0;
            sprite_addr <= '0;
        end else begin
            bus_out     <= bus_nxt;
            sprite_addr <= addr_nxt;
        end
    end

endmodule

`default_nettype wire

// File: hdl/video_top.sv
// Video pipeline top level.
// Timing generator, background grid, sprite overlay and the sprite
// image memory, one pixel per clock, four cycles from counters to
// video_out.

`default_nettype none

module video_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire video_pkg::pos_t  xpos,
    input  wire video_pkg::pos_t  ypos,
    input  wire logic              rotate,
    output video_pkg::video_bus_t video_out
);

    video_pkg::video_bus_t   timing_bus;
    video_pkg::video_bus_t   bg_bus;
    video_pkg::sprite_addr_t sprite_addr;
    video_pkg::rgb_t         sprite_rgb;

    vga_timing u_vga_timing (
        .clk,
        .rst,
        .timing(timing_bus)
    );

    draw_background u_draw_background (
        .clk,
        .rst,
        .bus_in (timing_bus),
        .bus_out(bg_bus)
    );

    draw_sprite u_draw_sprite (
        .clk,
        .rst,
        .xpos,
        .ypos,
        .rotate,
        .sprite_rgb,
        .sprite_addr,
        .bus_in (bg_bus),
        .bus_out(video_out)
    );

    sprite_rom u_sprite_rom (
        .clk,
        .addr(sprite_addr),
        .rgb (sprite_rgb)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// Testbench clock and reset source.
// Free-running clock and a synchronous reset held for a fixed
// number of rising edges, released just after an edge.

`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;                           // released off the edge.
    end

endmodule

`default_nettype wire

// File: test/video_top_tb.sv
// Testbench for the video pipeline top level.
// Runs two frames with a fixed sprite, moves it to an LFSR-chosen
// spot with mirroring during vertical blank, runs two more frames.
// A reference model predicts each video_out word from its own counts.

`default_nettype none

`include "video_config.svh"

module video_top_tb;

    localparam int RESET_CYCLES   = 8;
    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + RESET_CYCLES;
    localparam logic [31:0] SEED  = 32'h2fa0f53e;

    logic                  clk;
    logic                  rst;
    video_pkg::pos_t       xpos;
    video_pkg::pos_t       ypos;
    logic                  rotate;
    video_pkg::video_bus_t video_out;

    video_pkg::video_bus_t prev_word;
    logic                  advanced;
    logic [31:0]           lfsr_state;
    int cycle_count   = 0;
    int rst_cycles    = 0;
    int run_cycles    = 0;
    int reset_errors  = 0;
    int timing_errors = 0;
    int colour_errors = 0;
    int reach_errors  = 0;
    int rot0_pixels   = 0;
    int rot1_pixels   = 0;
    int old_box_pixels = 0;
    int old_x;
    int old_y;
    int rand_x;
    int rand_y;
    int total_errors;

    tb_clock_gen #(
        .PERIOD(10),
        .RESET_CYCLES(RESET_CYCLES)
    ) u_clock_gen (
        .clk,
        .rst
    );

    video_top dut_i (
        .clk,
        .rst,
        .xpos,
        .ypos,
        .rotate,
        .video_out
    );

    function automatic video_pkg::coord_t next_hcount(input video_pkg::coord_t h);
        if (int'(h) == `H_TOTAL - 1) begin
            return '0;
        end
        return video_pkg::coord_t'(int'(h) + 1);
    endfunction

    function automatic video_pkg::coord_t next_vcount(input video_pkg::coord_t h,
                                                     input video_pkg::coord_t v);
        if (int'(h) != `H_TOTAL - 1) begin
            return v;
        end
        if (int'(v) == `V_TOTAL - 1) begin
            return '0;
        end
        return video_pkg::coord_t'(int'(v) + 1);
    endfunction

    function automatic logic sync_rule(input int c, input int active, input int front,
                                       input int width);
        return (c >= active + front) && (c < active + front + width);
    endfunction

    function automatic logic inside_box(input int h, input int v, input int x, input int y);
        return (h >= x) && (h < x + `SPRITE_WIDTH) && (v >= y) && (v < y + `SPRITE_HEIGHT);
    endfunction

    // coarse grid, red from the column band, green from the row band.
    function automatic video_pkg::rgb_t grid_rgb(input int h, input int v);
        return video_pkg::rgb_t'((((h >> 5) & 15) << 8) | (((v >> 5) & 15) << 4));
    endfunction

    function automatic video_pkg::rgb_t sprite_pixel_rgb(input int x_off, input int row,
                                                          input logic mirror);
        int col;
        col = mirror ? (`SPRITE_WIDTH - 1 - x_off) : x_off;
        return video_pkg::rgb_t'((((row >> 2) & 15) << 8) | (((col >> 2) & 15) << 4) | 12);
    endfunction

    // fibonacci LFSR, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_vblank_rise();
        while (video_out.vblnk) begin
            step_clock();
        end
        while (!video_out.vblnk) begin
            step_clock();
        end
    endtask

    task automatic print_counts();
        $display("errors: reset %0d, timing %0d, colour %0d, coverage %0d", reset_errors,
                 timing_errors, colour_errors, reach_errors);
    endtask

    // prediction from the word's own counts.
    int              h_now;
    int              v_now;
    logic            any_blank;
    logic            box_hit;
    logic            check_on;
    video_pkg::rgb_t grid_exp;
    video_pkg::rgb_t sprite_exp;

    assign h_now      = int'(video_out.hcount);
    assign v_now      = int'(video_out.vcount);
    assign any_blank  = video_out.hblnk || video_out.vblnk;
    assign box_hit    = inside_box(h_now, v_now, int'(xpos), int'(ypos));
    assign check_on   = (run_cycles >= 2);
    assign grid_exp   = grid_rgb(h_now, v_now);
    assign sprite_exp = sprite_pixel_rgb(h_now - int'(xpos), v_now - int'(ypos), rotate);

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (rst) begin
            rst_cycles <= rst_cycles + 1;
            run_cycles <= 0;
            advanced   <= 1'b0;
        end else begin
            run_cycles <= run_cycles + 1;
            if (video_out.hcount != '0) begin
                advanced <= 1'b1;                // pipeline has filled.
            end
        end
        prev_word <= video_out;
    end

    a_reset_zero: assert property (@(posedge clk)
        ((rst && rst_cycles >= 1) || (!rst && run_cycles <= 1)) |-> (video_out == '0))
    else begin
        reset_errors = reset_errors + 1;
        $display("MISMATCH t=%0t video_out expected %h actual %h", $time,
                 video_pkg::video_bus_t'(0), $sampled(video_out));
    end

    a_hcount: assert property (@(posedge clk) disable iff (rst)
        advanced |-> (video_out.hcount == next_hcount(prev_word.hcount)))
    else begin
        timing_errors = timing_errors + 1;
        $display("MISMATCH t=%0t video_out.hcount expected %0d actual %0d", $time,
                 next_hcount($sampled(prev_word.hcount)), $sampled(video_out.hcount));
    end

    a_vcount: assert property (@(posedge clk) disable iff (rst)
        advanced |-> (video_out.vcount == next_vcount(prev_word.hcount, prev_word.vcount)))
    else begin
        timing_errors = timing_errors + 1;
        $display("MISMATCH t=%0t video_out.vcount expected %0d actual %0d", $time,
                 next_vcount($sampled(prev_word.hcount), $sampled(prev_word.vcount)),
                 $sampled(video_out.vcount));
    end

    a_flags: assert property (@(posedge clk) disable iff (rst)
        check_on |-> ({video_out.hsync, video_out.hblnk, video_out.vsync, video_out.vblnk} ==
                      {sync_rule(h_now, `H_ACTIVE, `H_FRONT, `H_SYNC), h_now >= `H_ACTIVE,
                       sync_rule(v_now, `V_ACTIVE, `V_FRONT, `V_SYNC), v_now >= `V_ACTIVE}))
    else begin
        timing_errors = timing_errors + 1;
        $display("MISMATCH t=%0t video_out.{hsync,hblnk,vsync,vblnk} expected %b%b%b%b actual %b",
                 $time, sync_rule($sampled(h_now), `H_ACTIVE, `H_FRONT, `H_SYNC),
                 $sampled(h_now) >= `H_ACTIVE,
                 sync_rule($sampled(v_now), `V_ACTIVE, `V_FRONT, `V_SYNC),
                 $sampled(v_now) >= `V_ACTIVE,
                 {$sampled(video_out.hsync), $sampled(video_out.hblnk),
                  $sampled(video_out.vsync), $sampled(video_out.vblnk)});
    end

    a_blank_rgb: assert property (@(posedge clk) disable iff (rst)
        (check_on && any_blank) |-> (video_out.rgb == `BLANK_RGB))
    else begin
        colour_errors = colour_errors + 1;
        $display("MISMATCH t=%0t video_out.rgb expected %h actual %h", $time, `BLANK_RGB,
                 $sampled(video_out.rgb));
    end

    a_background: assert property (@(posedge clk) disable iff (rst)
        (check_on && !any_blank && !box_hit) |-> (video_out.rgb == grid_exp))
    else begin
        colour_errors = colour_errors + 1;
        $display("MISMATCH t=%0t video_out.rgb expected %h actual %h", $time,
                 $sampled(grid_exp), $sampled(video_out.rgb));
    end

    a_sprite: assert property (@(posedge clk) disable iff (rst)
        (check_on && !any_blank && box_hit) |-> (video_out.rgb == sprite_exp))
    else begin
        colour_errors = colour_errors + 1;
        $display("MISMATCH t=%0t video_out.rgb expected %h actual %h", $time,
                 $sampled(sprite_exp), $sampled(video_out.rgb));
    end

    // count which kinds of pixel were actually checked.
    always @(posedge clk) begin
        if (check_on && !rst && !any_blank) begin
            if (box_hit && !rotate) begin
                rot0_pixels <= rot0_pixels + 1;
            end
            if (box_hit && rotate) begin
                rot1_pixels <= rot1_pixels + 1;
            end
            if (rotate && !box_hit && inside_box(h_now, v_now, old_x, old_y)) begin
                old_box_pixels <= old_box_pixels + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        xpos       = video_pkg::pos_t'(100);
        ypos       = video_pkg::pos_t'(50);
        rotate     = 1'b0;
        lfsr_state = SEED;
        old_x      = 0;
        old_y      = 0;
        @(negedge rst);
        wait_vblank_rise();                      // end of frame 1.
        wait_vblank_rise();                      // end of frame 2.
        repeat (8) step_clock();
        old_x = int'(xpos);
        old_y = int'(ypos);
        take_bits(10, rand_x);
        take_bits(9, rand_y);
        xpos   = video_pkg::pos_t'(rand_x % (`H_ACTIVE - `SPRITE_WIDTH + 1));
        ypos   = video_pkg::pos_t'(rand_y % (`V_ACTIVE - `SPRITE_HEIGHT + 1));
        rotate = 1'b1;
        wait_vblank_rise();
        wait_vblank_rise();
        repeat (8) step_clock();
        if (rot0_pixels == 0) begin
            $display("no sprite pixel was checked with rotate 0");
            reach_errors = reach_errors + 1;
        end
        if (rot1_pixels == 0) begin
            $display("no mirrored sprite pixel was checked after the move");
            reach_errors = reach_errors + 1;
        end
        if (old_box_pixels == 0) begin
            $display("no pixel of the old sprite location was checked after the move");
            reach_errors = reach_errors + 1;
        end
        total_errors = reset_errors + timing_errors + colour_errors + reach_errors;
        print_counts();
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
hdl/video_pkg.sv
hdl/vga_timing.sv
hdl/draw_background.sv
hdl/bus_delay.sv
hdl/sprite_rom.sv
hdl/draw_sprite.sv
hdl/video_top.sv
test/tb_clock_gen.sv
test/video_top_tb.sv

// File: Makefile
# Verilator build and run for the video pipeline testbench.
# Every variable can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= video_top_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --assert
PASS_TEXT ?= ^Simulation finished: PASS$$

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
